// File: common/vga_pkg.sv
package vga_pkg;

    // pixel coordinate width, enough for 1344 total columns
    localparam int COORD_W = 11;

    // 0 is an empty tile, n stands for 2**n
    typedef logic [3:0] tile_exp_t;

    // tile index row*4+col, tile 0 in the lowest nibble
    typedef tile_exp_t [15:0] board_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    typedef struct packed {
        logic [COORD_W-1:0] x;
        logic [COORD_W-1:0] y;
        logic               active; // inside the visible area
    } pix_pos_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;  // byte address
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    localparam logic [7:0] ADDR_BOARD_LO = 8'h00; // tiles 0..7
    localparam logic [7:0] ADDR_BOARD_HI = 8'h04; // tiles 8..15
    localparam logic [7:0] ADDR_CTRL     = 8'h08; // bit 0 commit

    // board placement in 64 pixel cells
    localparam int CELL_SHIFT = 6;
    localparam int BOARD_ROW0 = 2;
    localparam int BOARD_COL0 = 1;

    localparam rgb_t COL_BLACK = 12'h000;
    localparam rgb_t COL_BG    = 12'hffe; // pale background
    localparam rgb_t COL_FRAME = 12'hbaa; // frame lines

    // tile fill by exponent, entry 13 covers 8192 and above
    localparam rgb_t TILE_COLOR [0:13] = '{
        12'hccb, // empty
        12'heed, // 2
        12'heec, // 4
        12'hfb7, // 8
        12'hf96, // 16
        12'hf75, // 32
        12'hf53, // 64
        12'hec7, // 128
        12'hec6, // 256
        12'h00c, // 512
        12'h3be, // 1024
        12'h009, // 2048
        12'h006, // 4096
        12'h003  // 8192
    };

endpackage

// File: design/sync_timing.sv
`timescale 1ns/1ps

module sync_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_TOTAL  = 800,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_TOTAL  = 525
) (
    input  logic              CP,
    input  logic              RST,
    output vga_pkg::pix_pos_t pos_o,
    output logic              frame_start_o,
    output logic              hsync_o,
    output logic              vsync_o
);

    localparam int CW = vga_pkg::COORD_W;

    localparam logic [CW-1:0] X_TOTAL  = CW'(H_TOTAL);
    localparam logic [CW-1:0] X_LAST   = CW'(H_TOTAL - 1);
    localparam logic [CW-1:0] Y_LAST   = CW'(V_TOTAL - 1);
    localparam logic [CW-1:0] X_ACTIVE = CW'(H_ACTIVE);
    localparam logic [CW-1:0] Y_ACTIVE = CW'(V_ACTIVE);
    localparam logic [CW-1:0] HS_START = CW'(H_ACTIVE + H_FRONT);
    localparam logic [CW-1:0] HS_END   = CW'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam logic [CW-1:0] VS_START = CW'(V_ACTIVE + V_FRONT);
    localparam logic [CW-1:0] VS_END   = CW'(V_ACTIVE + V_FRONT + V_SYNC);

    logic [CW-1:0] x_q;
    logic [CW-1:0] y_q;

    always_ff @(posedge CP or posedge RST) begin
        if (RST) begin
            x_q <= '0;
            y_q <= '0;
        end else if (x_q == X_LAST) begin
            x_q <= '0;
            if (y_q == Y_LAST) begin
                y_q <= '0; // frame wrap
            end else begin
                y_q <= y_q + 1'b1;
            end
        end else begin
            x_q <= x_q + 1'b1;
        end
    end

    assign pos_o = '{x: x_q, y: y_q, active: (x_q < X_ACTIVE) && (y_q < Y_ACTIVE)};
    assign frame_start_o = (x_q == '0) && (y_q == '0);

    // sync outputs lag the counter by one edge, in step with rgb_o
    always_ff @(posedge CP or posedge RST) begin
        if (RST) begin
            hsync_o <= 1'b1;
        end else if (x_q == HS_START) begin
            hsync_o <= 1'b0;
        end else if (x_q == HS_END) begin
            hsync_o <= 1'b1;
        end
    end

    always_ff @(posedge CP or posedge RST) begin
        if (RST) begin
            vsync_o <= 1'b1;
        end else if (x_q == '0) begin // line boundary only
            if (y_q == VS_START) begin
                vsync_o <= 1'b0;
            end else if (y_q == VS_END) begin
                vsync_o <= 1'b1;
            end
        end
    end

    x_range_a: assert property (@(posedge CP) disable iff (RST) x_q < X_TOTAL);

    // pulse width, checked on each rising edge
    hsync_width_a: assert property (@(posedge CP) disable iff (RST)
        $rose(hsync_o) |-> !$past(hsync_o, H_SYNC) && $past(hsync_o, H_SYNC + 1));

endmodule

// File: design/apb_board_regs.sv
`timescale 1ns/1ps

module apb_board_regs (
    input  logic              CP,
    input  logic              RST,
    input  vga_pkg::apb_req_t apb_req_i,
    output vga_pkg::apb_rsp_t apb_rsp_o,
    input  logic              frame_start_i,
    output vga_pkg::board_t   board_o
);

    logic            access;
    logic            wr_en;
    logic            hit_lo;
    logic            hit_hi;
    logic            hit_ctrl;
    logic            hit_any;
    logic            commit_wr;
    logic [31:0]     rdata;
    logic            commit_q;
    vga_pkg::board_t staging_q;
    vga_pkg::board_t shadow_q;

    assign access    = apb_req_i.psel && apb_req_i.penable; // access phase
    assign wr_en     = access && apb_req_i.pwrite;
    assign hit_lo    = apb_req_i.paddr == vga_pkg::ADDR_BOARD_LO;
    assign hit_hi    = apb_req_i.paddr == vga_pkg::ADDR_BOARD_HI;
    assign hit_ctrl  = apb_req_i.paddr == vga_pkg::ADDR_CTRL;
    assign hit_any   = hit_lo || hit_hi || hit_ctrl;
    assign commit_wr = wr_en && hit_ctrl && apb_req_i.pwdata[0];

    // staging board written freely by game logic
    always_ff @(posedge CP or posedge RST) begin
        if (RST) begin
            staging_q <= '0;
        end else if (wr_en) begin
            if (hit_lo) begin
                staging_q[7:0] <= apb_req_i.pwdata;
            end
            if (hit_hi) begin
                staging_q[15:8] <= apb_req_i.pwdata;
            end
        end
    end

    // a new commit wins over the clear and waits for the next frame
    always_ff @(posedge CP or posedge RST) begin
        if (RST) begin
            commit_q <= 1'b0;
        end else if (commit_wr) begin
            commit_q <= 1'b1;
        end else if (frame_start_i) begin
            commit_q <= 1'b0;
        end
    end

    // shadow only moves at frame start so a frame is never torn
    always_ff @(posedge CP or posedge RST) begin
        if (RST) begin
            shadow_q <= '0;
        end else if (frame_start_i && commit_q) begin
            shadow_q <= staging_q;
        end
    end

    always_comb begin
        rdata = '0;
        if (access) begin
            if (hit_lo) begin
                rdata = staging_q[7:0];
            end else if (hit_hi) begin
                rdata = staging_q[15:8];
            end else if (hit_ctrl) begin
                rdata = {31'b0, commit_q}; // pending flag
            end
        end
    end

    assign apb_rsp_o = '{prdata: rdata, pready: 1'b1, pslverr: access && !hit_any};
    assign board_o   = shadow_q;

    penable_psel_a: assert property (@(posedge CP) disable iff (RST)
        apb_req_i.penable |-> apb_req_i.psel);

endmodule

// File: render/tile_renderer.sv
`timescale 1ns/1ps

module tile_renderer (
    input  logic              CP,
    input  logic              RST,
    input  vga_pkg::pix_pos_t pos_i,
    input  vga_pkg::board_t   board_i,
    output vga_pkg::rgb_t     rgb_o
);

    localparam int CW     = vga_pkg::COORD_W;
    localparam int SHIFT  = vga_pkg::CELL_SHIFT;
    localparam int CELL_W = CW - SHIFT;

    // last 4 pixels of a cell form the frame line
    localparam logic [SHIFT-1:0] FRAME_OFS = SHIFT'(60);

    localparam logic [CELL_W-1:0] ROW0     = CELL_W'(vga_pkg::BOARD_ROW0);
    localparam logic [CELL_W-1:0] COL0     = CELL_W'(vga_pkg::BOARD_COL0);
    localparam logic [CELL_W-1:0] ROW_TOP  = CELL_W'(vga_pkg::BOARD_ROW0 - 1);
    localparam logic [CELL_W-1:0] COL_LEFT = CELL_W'(vga_pkg::BOARD_COL0 - 1);
    localparam logic [CELL_W-1:0] SPAN     = CELL_W'(4); // 4x4 tiles

    localparam vga_pkg::tile_exp_t EXP_LAST = 4'd13;

    logic [CELL_W-1:0]  cell_x;
    logic [CELL_W-1:0]  cell_y;
    logic [SHIFT-1:0]   ofs_x;
    logic [SHIFT-1:0]   ofs_y;
    logic [CELL_W-1:0]  col_rel;
    logic [CELL_W-1:0]  row_rel;
    logic               in_cols;
    logic               in_rows;
    logic               line_x;
    logic               line_y;
    logic               in_board;
    logic               in_top_edge;
    logic               in_left_edge;
    logic [3:0]         tile_idx;
    vga_pkg::tile_exp_t tile_exp;
    vga_pkg::rgb_t      tile_col;
    vga_pkg::rgb_t      pix_col;

    // cell number from the upper bits, offset from the lower
    assign cell_x = pos_i.x[CW-1:SHIFT];
    assign cell_y = pos_i.y[CW-1:SHIFT];
    assign ofs_x  = pos_i.x[SHIFT-1:0];
    assign ofs_y  = pos_i.y[SHIFT-1:0];

    // relative to the board corner, wraps high when left of or above it
    assign col_rel = cell_x - COL0;
    assign row_rel = cell_y - ROW0;
    assign in_cols = col_rel < SPAN;
    assign in_rows = row_rel < SPAN;

    assign line_x = ofs_x >= FRAME_OFS;
    assign line_y = ofs_y >= FRAME_OFS;

    assign in_board     = in_rows && in_cols;
    assign in_top_edge  = (cell_y == ROW_TOP) && in_cols;  // strip above row 0
    assign in_left_edge = (cell_x == COL_LEFT) && in_rows; // strip left of col 0

    assign tile_idx = {row_rel[1:0], col_rel[1:0]}; // row*4+col
    assign tile_exp = board_i[tile_idx];

    always_comb begin
        if (tile_exp >= EXP_LAST) begin
            tile_col = vga_pkg::TILE_COLOR[EXP_LAST]; // 8192 and above
        end else begin
            tile_col = vga_pkg::TILE_COLOR[tile_exp];
        end
    end

    always_comb begin
        if (!pos_i.active) begin
            pix_col = vga_pkg::COL_BLACK; // blanking
        end else if (in_board) begin
            if (line_x || line_y) begin
                pix_col = vga_pkg::COL_FRAME;
            end else begin
                pix_col = tile_col;
            end
        end else if (in_top_edge) begin
            if (line_y) begin
                pix_col = vga_pkg::COL_FRAME; // outer frame top
            end else begin
                pix_col = vga_pkg::COL_BG;
            end
        end else if (in_left_edge) begin
            if (line_x) begin
                pix_col = vga_pkg::COL_FRAME; // outer frame left
            end else begin
                pix_col = vga_pkg::COL_BG;
            end
        end else begin
            pix_col = vga_pkg::COL_BG;
        end
    end

    // one cycle behind the position, same as the sync outputs
    always_ff @(posedge CP or posedge RST) begin
        if (RST) begin
            rgb_o <= vga_pkg::COL_BLACK;
        end else begin
            rgb_o <= pix_col;
        end
    end

    blank_black_a: assert property (@(posedge CP) disable iff (RST)
        !pos_i.active |=> rgb_o == vga_pkg::COL_BLACK);

endmodule

// File: design/vga_top.sv
`timescale 1ns/1ps

module vga_top #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_TOTAL  = 800,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_TOTAL  = 525
) (
    input  logic              CP,
    input  logic              RST,
    input  vga_pkg::apb_req_t apb_req_i,
    output vga_pkg::apb_rsp_t apb_rsp_o,
    output logic              hsync_o,
    output logic              vsync_o,
    output vga_pkg::rgb_t     rgb_o
);

    vga_pkg::pix_pos_t pos;
    logic              frame_start;
    vga_pkg::board_t   shown_board; // shadow copy, stable for a whole frame

    sync_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_TOTAL  (H_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_TOTAL  (V_TOTAL)
    ) u_sync_timing (
        .CP            (CP),
        .RST           (RST),
        .pos_o         (pos),
        .frame_start_o (frame_start),
        .hsync_o       (hsync_o),
        .vsync_o       (vsync_o)
    );

    apb_board_regs u_apb_board_regs (
        .CP            (CP),
        .RST           (RST),
        .apb_req_i     (apb_req_i),
        .apb_rsp_o     (apb_rsp_o),
        .frame_start_i (frame_start),
        .board_o       (shown_board)
    );

    tile_renderer u_tile_renderer (
        .CP      (CP),
        .RST     (RST),
        .pos_i   (pos),
        .board_i (shown_board),
        .rgb_o   (rgb_o)
    );

endmodule

// File: test/vga_tb.sv
`timescale 1ns/1ps

module vga_tb;

    localparam int CLK_PERIOD      = 100;
    localparam int H_ACTIVE        = 640;
    localparam int H_FRONT         = 16;
    localparam int H_SYNC          = 96;
    localparam int H_TOTAL         = 800;
    localparam int V_ACTIVE        = 480;
    localparam int V_FRONT         = 10;
    localparam int V_SYNC          = 2;
    localparam int V_TOTAL         = 525;
    localparam int HS_START        = H_ACTIVE + H_FRONT;
    localparam int HS_END          = H_ACTIVE + H_FRONT + H_SYNC;
    localparam int VS_START        = V_ACTIVE + V_FRONT;
    localparam int VS_END          = V_ACTIVE + V_FRONT + V_SYNC;
    localparam int FRAME_CYCLES    = H_TOTAL * V_TOTAL;
    localparam int WATCHDOG_CYCLES = FRAME_CYCLES * 16 / 5; // 3.2 frames
    localparam int CELL            = 1 << vga_pkg::CELL_SHIFT;
    localparam int LINE_OFS        = CELL - 4; // frame line is the last 4 pixels
    localparam int APB_MAX_WAIT    = 16;

    logic              CP;
    logic              RST;
    vga_pkg::apb_req_t apb_req;
    vga_pkg::apb_rsp_t apb_rsp;
    logic              hsync;
    logic              vsync;
    vga_pkg::rgb_t     rgb;

    int            seed;
    int            rgb_errs;
    int            sync_errs;
    int            apb_errs;
    int            mdl_x;
    int            mdl_y;
    int            frame_cnt; // counts frame starts seen by the model
    logic [63:0]   mdl_staging;
    logic [63:0]   mdl_shadow;
    logic          mdl_pending;
    logic          exp_valid;
    vga_pkg::rgb_t exp_rgb;
    logic          exp_hs;
    logic          exp_vs;
    int            exp_x;
    int            exp_y;

    vga_top #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_TOTAL  (H_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_TOTAL  (V_TOTAL)
    ) dut0 (
        .CP        (CP),
        .RST       (RST),
        .apb_req_i (apb_req),
        .apb_rsp_o (apb_rsp),
        .hsync_o   (hsync),
        .vsync_o   (vsync),
        .rgb_o     (rgb)
    );

    initial begin
        CP = 1'b0;
        forever #(CLK_PERIOD / 2) CP = ~CP;
    end

    function automatic vga_pkg::rgb_t pixel_color(input int x, input int y,
                                                  input logic [63:0] brd);
        int                 cx;
        int                 cy;
        int                 ox;
        int                 oy;
        logic [5:0]         bit_lo;
        vga_pkg::tile_exp_t e;
        cx = x / CELL;
        cy = y / CELL;
        ox = x % CELL;
        oy = y % CELL;
        if (x >= H_ACTIVE || y >= V_ACTIVE) begin
            return vga_pkg::COL_BLACK;
        end
        if (cy >= 2 && cy <= 5 && cx >= 1 && cx <= 4) begin
            if (ox >= LINE_OFS || oy >= LINE_OFS) begin
                return vga_pkg::COL_FRAME;
            end
            bit_lo = 6'(((cy - 2) * 4 + (cx - 1)) * 4); // tile 0 in the low nibble
            e = brd[bit_lo +: 4];
            if (e > 4'd13) begin
                e = 4'd13;
            end
            return vga_pkg::TILE_COLOR[e];
        end
        if (cy == 1 && cx >= 1 && cx <= 4) begin
            return (oy >= LINE_OFS) ? vga_pkg::COL_FRAME : vga_pkg::COL_BG;
        end
        if (cx == 0 && cy >= 2 && cy <= 5) begin
            return (ox >= LINE_OFS) ? vga_pkg::COL_FRAME : vga_pkg::COL_BG;
        end
        return vga_pkg::COL_BG;
    endfunction

    task automatic check_rgb(input string name, input vga_pkg::rgb_t got,
                             input vga_pkg::rgb_t exp);
        if (got !== exp) begin
            rgb_errs++;
            $display("[FAIL] %s got 0x%03h expected 0x%03h at x=%0d y=%0d",
                     name, got, exp, exp_x, exp_y);
        end
    endtask

    task automatic check_sync(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            sync_errs++;
            $display("[FAIL] %s got 0x%01h expected 0x%01h at x=%0d y=%0d",
                     name, got, exp, exp_x, exp_y);
        end
    endtask

    // prdata only counts on a transfer without error
    task automatic check_apb(input string name, input logic [31:0] got_data,
                             input logic got_err, input logic [31:0] exp_data,
                             input logic exp_err);
        if (got_err !== exp_err || (!exp_err && got_data !== exp_data)) begin
            apb_errs++;
            $display("[FAIL] %s prdata 0x%08h pslverr 0x%01h expected 0x%08h 0x%01h",
                     name, got_data, got_err, exp_data, exp_err);
        end
    endtask

    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int waits;
        @(negedge CP);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(negedge CP);
        apb_req.penable = 1'b1; // access phase
        #(CLK_PERIOD / 4);
        waits = 0;
        while (!apb_rsp.pready && waits < APB_MAX_WAIT) begin
            @(negedge CP);
            #(CLK_PERIOD / 4);
            waits++;
        end
        if (!apb_rsp.pready) begin
            apb_errs++;
            $display("APB transfer to address 0x%02h never completed", addr);
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(negedge CP);
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata,
                             output logic err);
        logic [31:0] unused_rdata;
        apb_transfer(1'b1, addr, wdata, unused_rdata, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata,
                            output logic err);
        apb_transfer(1'b0, addr, 32'h0, rdata, err);
    endtask

    // model of counter, sync and board registers stepped once per edge
    always @(posedge CP) begin : model
        logic fs;
        logic commit_wr;
        if (!RST) begin
            exp_x   = mdl_x;
            exp_y   = mdl_y;
            exp_rgb = pixel_color(mdl_x, mdl_y, mdl_shadow);
            if (mdl_x == HS_START) begin
                exp_hs = 1'b0;
            end else if (mdl_x == HS_END) begin
                exp_hs = 1'b1;
            end
            if (mdl_x == 0 && mdl_y == VS_START) begin
                exp_vs = 1'b0;
            end else if (mdl_x == 0 && mdl_y == VS_END) begin
                exp_vs = 1'b1;
            end
            exp_valid = 1'b1;
            fs        = (mdl_x == 0) && (mdl_y == 0);
            commit_wr = 1'b0;
            if (fs) begin
                frame_cnt++;
                if (mdl_pending) begin
                    mdl_shadow = mdl_staging; // old staging value
                end
            end
            if (apb_req.psel && apb_req.penable && apb_req.pwrite) begin
                case (apb_req.paddr)
                    vga_pkg::ADDR_BOARD_LO: mdl_staging[31:0]  = apb_req.pwdata;
                    vga_pkg::ADDR_BOARD_HI: mdl_staging[63:32] = apb_req.pwdata;
                    vga_pkg::ADDR_CTRL:     commit_wr = apb_req.pwdata[0];
                    default:                commit_wr = 1'b0; // unmapped address is ignored
                endcase
            end
            if (commit_wr) begin
                mdl_pending = 1'b1;
            end else if (fs) begin
                mdl_pending = 1'b0;
            end
            if (mdl_x == H_TOTAL - 1) begin
                mdl_x = 0;
                mdl_y = (mdl_y == V_TOTAL - 1) ? 0 : mdl_y + 1;
            end else begin
                mdl_x = mdl_x + 1;
            end
        end
    end

    always @(negedge CP) begin
        if (exp_valid) begin
            check_rgb("rgb_o", rgb, exp_rgb);
            check_sync("hsync_o", hsync, exp_hs);
            check_sync("vsync_o", vsync, exp_vs);
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CP);
        $display("watchdog expired after %0d cycles at frame %0d", WATCHDOG_CYCLES, frame_cnt);
        $display("Errors found");
        $finish;
    end

    initial begin
        logic [63:0] brd_a;
        logic [63:0] brd_b;
        logic [31:0] rdata;
        logic        err;
        seed        = 32'h7aee_18c0;
        rgb_errs    = 0;
        sync_errs   = 0;
        apb_errs    = 0;
        mdl_x       = 0;
        mdl_y       = 0;
        frame_cnt   = 0;
        mdl_staging = '0;
        mdl_shadow  = '0;
        mdl_pending = 1'b0;
        exp_valid   = 1'b0;
        exp_hs      = 1'b1;
        exp_vs      = 1'b1;
        RST         = 1'b1;
        apb_req     = '0;
        repeat (3) @(posedge CP);
        @(negedge CP);
        check_sync("hsync_o", hsync, 1'b1);
        check_sync("vsync_o", vsync, 1'b1);
        check_rgb("rgb_o", rgb, vga_pkg::COL_BLACK);
        RST = 1'b0;

        wait (frame_cnt == 1);
        brd_a = {$random(seed), $random(seed)};
        apb_write(vga_pkg::ADDR_BOARD_LO, brd_a[31:0], err);
        check_apb("board_lo write", 32'h0, err, 32'h0, 1'b0);
        apb_write(vga_pkg::ADDR_BOARD_HI, brd_a[63:32], err);
        check_apb("board_hi write", 32'h0, err, 32'h0, 1'b0);
        apb_write(vga_pkg::ADDR_CTRL, 32'h1, err);
        check_apb("ctrl write", 32'h0, err, 32'h0, 1'b0);
        apb_read(vga_pkg::ADDR_BOARD_LO, rdata, err);
        check_apb("board_lo read", rdata, err, brd_a[31:0], 1'b0);
        apb_read(vga_pkg::ADDR_BOARD_HI, rdata, err);
        check_apb("board_hi read", rdata, err, brd_a[63:32], 1'b0);
        apb_read(vga_pkg::ADDR_CTRL, rdata, err);
        check_apb("ctrl pending", rdata, err, 32'h1, 1'b0);

        wait (frame_cnt == 2); // board a on screen from here
        apb_read(vga_pkg::ADDR_CTRL, rdata, err);
        check_apb("ctrl cleared", rdata, err, 32'h0, 1'b0);
        brd_b = {$random(seed), $random(seed)};
        brd_b[63:52] = 12'hfed; // exponents 15, 14, 13
        apb_write(vga_pkg::ADDR_BOARD_LO, brd_b[31:0], err);
        check_apb("board_lo write", 32'h0, err, 32'h0, 1'b0);
        apb_write(vga_pkg::ADDR_BOARD_HI, brd_b[63:32], err);
        check_apb("board_hi write", 32'h0, err, 32'h0, 1'b0);
        apb_write(8'h0c, 32'hffff_ffff, err);
        check_apb("unmapped write", 32'h0, err, 32'h0, 1'b1);
        apb_read(8'h0c, rdata, err);
        check_apb("unmapped read", rdata, err, 32'h0, 1'b1);
        apb_read(vga_pkg::ADDR_BOARD_LO, rdata, err);
        check_apb("board_lo read", rdata, err, brd_b[31:0], 1'b0);
        apb_read(vga_pkg::ADDR_BOARD_HI, rdata, err);
        check_apb("board_hi read", rdata, err, brd_b[63:32], 1'b0);
        apb_read(vga_pkg::ADDR_CTRL, rdata, err);
        check_apb("ctrl idle", rdata, err, 32'h0, 1'b0);

        wait (mdl_y >= V_ACTIVE); // commit late in the frame
        apb_write(vga_pkg::ADDR_CTRL, 32'h1, err);
        check_apb("ctrl write", 32'h0, err, 32'h0, 1'b0);
        apb_read(vga_pkg::ADDR_CTRL, rdata, err);
        check_apb("ctrl pending", rdata, err, 32'h1, 1'b0);

        wait (frame_cnt == 3);
        apb_read(vga_pkg::ADDR_CTRL, rdata, err);
        check_apb("ctrl cleared", rdata, err, 32'h0, 1'b0);

        wait (frame_cnt == 4);
        @(negedge CP);
        #(CLK_PERIOD / 4); // let the compare at this falling edge finish first
        $display("error counts: rgb %0d, sync %0d, apb %0d", rgb_errs, sync_errs, apb_errs);
        if (rgb_errs == 0 && sync_errs == 0 && apb_errs == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: flist.f
common/vga_pkg.sv
design/sync_timing.sv
design/apb_board_regs.sv
render/tile_renderer.sv
design/vga_top.sv
test/vga_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the VGA testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert \
    --top-module vga_tb \
    -f flist.f \
    -o vga_sim \
    && ./obj_dir/vga_sim > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "simulation build or run failed"; exit 1; }

cat "$LOG"

grep -qx "No errors" "$LOG" \
    && { echo "result: PASS"; exit 0; } \
    || { echo "result: FAIL"; exit 1; }
